/* hw/stap_defines.svh */
// *******************************************************************
// Build-time constants of the sTAP: sub-TAP count, IR width, IDCODE
// Included by the register package, the tap network and the top
// *******************************************************************
`ifndef STAP_DEFINES_SVH
`define STAP_DEFINES_SVH

// *******************************************************************
// Tap network size
// *******************************************************************
// Sub-TAPs behind this sTAP, two select bits each
`define STAP_NUM_TAPS 4

// *******************************************************************
// Instruction register
// *******************************************************************
`define STAP_IR_WIDTH 8

// *******************************************************************
// Identification
// *******************************************************************
// Bit 0 is one as 1149.1 requires
`define STAP_IDCODE 32'h0B41_7C0F

`endif

/* hw/stap_fsm_pkg.sv */
// *******************************************************************
// TAP controller state encoding, shared by the FSM, top and testbench
// *******************************************************************
`default_nettype none

package stap_fsm_pkg;

   // 1149.1 style encoding
   typedef enum logic [3:0]
   {
      TLR        = 4'hF,
      RTI        = 4'hC,
      SELECT_DR  = 4'h7,
      CAPTURE_DR = 4'h6,
      SHIFT_DR   = 4'h2,
      EXIT1_DR   = 4'h1,
      PAUSE_DR   = 4'h3,
      EXIT2_DR   = 4'h0,
      UPDATE_DR  = 4'h5,
      SELECT_IR  = 4'h4,
      CAPTURE_IR = 4'hE,
      SHIFT_IR   = 4'hA,
      EXIT1_IR   = 4'h9,
      PAUSE_IR   = 4'hB,
      EXIT2_IR   = 4'h8,
      UPDATE_IR  = 4'hD
   } tap_state_t;

endpackage

`default_nettype wire

/* hw/stap_reg_pkg.sv */
// *******************************************************************
// Register payload types of the sTAP: instruction, select, IDCODE
// *******************************************************************
`default_nettype none

`include "stap_defines.svh"

package stap_reg_pkg;

   // *******************************************************************
   // Instruction register
   // *******************************************************************
   typedef logic [`STAP_IR_WIDTH-1:0] ir_t;

   // Unlisted codes decode as bypass
   typedef enum ir_t
   {
      IR_IDCODE      = `STAP_IR_WIDTH'('h02),
      IR_TAPC_SELECT = `STAP_IR_WIDTH'('h11),
      IR_BYPASS      = {`STAP_IR_WIDTH{1'b1}}
   } ir_opcode_t;

   // Low IR bits at Capture-IR, upper bits zero
   localparam logic [1:0] IR_CAPTURE = 2'b01;

   // *******************************************************************
   // Tap network select
   // *******************************************************************
   typedef enum logic [1:0]
   {
      MODE_ISOLATED = 2'b00,
      MODE_NORMAL   = 2'b01,
      MODE_WIR_ONLY = 2'b10,  // TDO only while in the IR path
      MODE_TAP_ONLY = 2'b11
   } tapnw_mode_t;

   typedef tapnw_mode_t [`STAP_NUM_TAPS-1:0] tapc_sel_t;

   // One bit per sub-TAP
   typedef logic [`STAP_NUM_TAPS-1:0] tap_vec_t;

   typedef logic [31:0] idcode_t;

endpackage

`default_nettype wire

/* hw/stap_fsm.sv */
// *******************************************************************
// 16-state TAP controller on tck with capture, shift, update strobes
// Strobes and the IR-path flag are decodes of the current state
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

module stap_fsm
   (
   input  logic                     tck,
   input  logic                     arst_n,
   input  logic                     tms,
   output stap_fsm_pkg::tap_state_t state,
   output logic                     capture_ir,
   output logic                     shift_ir,
   output logic                     update_ir,
   output logic                     capture_dr,
   output logic                     shift_dr,
   output logic                     update_dr,
   output logic                     ir_path,
   output logic                     tlr
   );

   stap_fsm_pkg::tap_state_t next_state;

   // *******************************************************************
   // State register
   // *******************************************************************
   always_ff @(posedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state <= stap_fsm_pkg::TLR;
      end
      else
      begin
         state <= next_state;
      end
   end

   // *******************************************************************
   // Transition table
   // *******************************************************************
   always_comb
   begin
      case (state)
         stap_fsm_pkg::TLR        : next_state = tms ? stap_fsm_pkg::TLR : stap_fsm_pkg::RTI;
         stap_fsm_pkg::RTI        : next_state = tms ? stap_fsm_pkg::SELECT_DR : stap_fsm_pkg::RTI;
         // DR column
         stap_fsm_pkg::SELECT_DR  : next_state = tms ? stap_fsm_pkg::SELECT_IR : stap_fsm_pkg::CAPTURE_DR;
         stap_fsm_pkg::CAPTURE_DR : next_state = tms ? stap_fsm_pkg::EXIT1_DR : stap_fsm_pkg::SHIFT_DR;
         stap_fsm_pkg::SHIFT_DR   : next_state = tms ? stap_fsm_pkg::EXIT1_DR : stap_fsm_pkg::SHIFT_DR;
         stap_fsm_pkg::EXIT1_DR   : next_state = tms ? stap_fsm_pkg::UPDATE_DR : stap_fsm_pkg::PAUSE_DR;
         stap_fsm_pkg::PAUSE_DR   : next_state = tms ? stap_fsm_pkg::EXIT2_DR : stap_fsm_pkg::PAUSE_DR;
         stap_fsm_pkg::EXIT2_DR   : next_state = tms ? stap_fsm_pkg::UPDATE_DR : stap_fsm_pkg::SHIFT_DR;
         stap_fsm_pkg::UPDATE_DR  : next_state = tms ? stap_fsm_pkg::SELECT_DR : stap_fsm_pkg::RTI;
         // IR column, TMS high from Select-IR falls back to reset
         stap_fsm_pkg::SELECT_IR  : next_state = tms ? stap_fsm_pkg::TLR : stap_fsm_pkg::CAPTURE_IR;
         stap_fsm_pkg::CAPTURE_IR : next_state = tms ? stap_fsm_pkg::EXIT1_IR : stap_fsm_pkg::SHIFT_IR;
         stap_fsm_pkg::SHIFT_IR   : next_state = tms ? stap_fsm_pkg::EXIT1_IR : stap_fsm_pkg::SHIFT_IR;
         stap_fsm_pkg::EXIT1_IR   : next_state = tms ? stap_fsm_pkg::UPDATE_IR : stap_fsm_pkg::PAUSE_IR;
         stap_fsm_pkg::PAUSE_IR   : next_state = tms ? stap_fsm_pkg::EXIT2_IR : stap_fsm_pkg::PAUSE_IR;
         stap_fsm_pkg::EXIT2_IR   : next_state = tms ? stap_fsm_pkg::UPDATE_IR : stap_fsm_pkg::SHIFT_IR;
         stap_fsm_pkg::UPDATE_IR  : next_state = tms ? stap_fsm_pkg::SELECT_DR : stap_fsm_pkg::RTI;
         default                  : next_state = stap_fsm_pkg::TLR;
      endcase
   end

   // *******************************************************************
   // State decodes
   // *******************************************************************
   assign tlr        = (state == stap_fsm_pkg::TLR);
   assign capture_ir = (state == stap_fsm_pkg::CAPTURE_IR);
   assign shift_ir   = (state == stap_fsm_pkg::SHIFT_IR);
   assign update_ir  = (state == stap_fsm_pkg::UPDATE_IR);
   assign capture_dr = (state == stap_fsm_pkg::CAPTURE_DR);
   assign shift_dr   = (state == stap_fsm_pkg::SHIFT_DR);
   assign update_dr  = (state == stap_fsm_pkg::UPDATE_DR);

   // Select-IR through Update-IR
   assign ir_path = state inside {stap_fsm_pkg::SELECT_IR, stap_fsm_pkg::CAPTURE_IR,
                                  stap_fsm_pkg::SHIFT_IR,  stap_fsm_pkg::EXIT1_IR,
                                  stap_fsm_pkg::PAUSE_IR,  stap_fsm_pkg::EXIT2_IR,
                                  stap_fsm_pkg::UPDATE_IR};

endmodule

`default_nettype wire

/* hw/stap_shift_reg.sv */
// *******************************************************************
// Capture/shift/update scan register, payload chosen by type parameter
// Shifts in at the MSB, serial output is the LSB
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

module stap_shift_reg
   #(
   parameter type payload_t = logic [7:0]
   )
   (
   input  logic     tck,
   input  logic     arst_n,
   input  logic     si,
   input  logic     capture,
   input  logic     shift,
   input  logic     update,
   input  logic     tlr,
   input  payload_t capture_val,
   input  payload_t reset_val,
   output logic     so,
   output payload_t data
   );

   localparam int unsigned WIDTH = $bits(payload_t);

   logic [WIDTH-1:0] shift_q;
   payload_t         update_q;

   // *******************************************************************
   // Shift stage
   // *******************************************************************
   always_ff @(posedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         shift_q <= reset_val;
      end
      else if (tlr)
      begin
         shift_q <= reset_val;
      end
      else if (capture)
      begin
         shift_q <= capture_val;
      end
      else if (shift)
      begin
         // New bit enters at the top
         shift_q <= {si, shift_q[WIDTH-1:1]};
      end
   end

   // *******************************************************************
   // Update stage
   // *******************************************************************
   always_ff @(posedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         update_q <= reset_val;
      end
      else if (tlr)
      begin
         update_q <= reset_val;
      end
      else if (update)
      begin
         update_q <= payload_t'(shift_q);
      end
   end

   assign so   = shift_q[0];
   assign data = update_q;

endmodule

`default_nettype wire

/* hw/stap_tapnw.sv */
// *******************************************************************
// Tap network control, turns each sub-TAP select pair into enables
// Purely combinational, select_ir comes from the falling-edge flag
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stap_defines.svh"

module stap_tapnw
   (
   input  logic                    select_ir,
   input  stap_reg_pkg::tapc_sel_t tapc_select,
   output stap_reg_pkg::tap_vec_t  enabletap,
   output stap_reg_pkg::tap_vec_t  enabletdo
   );

   // *******************************************************************
   // Per sub-TAP decode
   // *******************************************************************
   for (genvar j = 0; j < `STAP_NUM_TAPS; j++)
   begin : g_tap
      // Any mode but isolated clocks the sub-TAP
      assign enabletap[j] = (tapc_select[j] != stap_reg_pkg::MODE_ISOLATED);

      // Normal always drives TDO
      // WIR-only drives it while the sTAP sits in the IR path
      // TAP-only never does
      assign enabletdo[j] = (tapc_select[j] == stap_reg_pkg::MODE_NORMAL) |
                            ((tapc_select[j] == stap_reg_pkg::MODE_WIR_ONLY) & select_ir);
   end

endmodule

`default_nettype wire

/* hw/stap_top.sv */
// *******************************************************************
// sTAP top: TAP FSM, IR, IDCODE, bypass, tap network select and TDO
// tms/tdi sampled on rising tck, tdo/tdo_en launched on falling tck
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stap_defines.svh"

module stap_top
   (
   input  logic                   tck,
   input  logic                   arst_n,
   input  logic                   tms,
   input  logic                   tdi,
   output logic                   tdo,
   output logic                   tdo_en,
   output stap_reg_pkg::tap_vec_t enabletap,
   output stap_reg_pkg::tap_vec_t enabletdo
   );

   // *******************************************************************
   // Internal signals
   // *******************************************************************
   stap_fsm_pkg::tap_state_t state;
   logic capture_ir, shift_ir, update_ir;
   logic capture_dr, shift_dr, update_dr;
   logic ir_path, tlr;

   stap_reg_pkg::ir_t       ir_data;
   stap_reg_pkg::tapc_sel_t sel_data;
   logic ir_so, id_so, sel_so;

   logic sel_idcode, sel_tapc, sel_bypass;
   logic bypass_q;
   logic ir_path_neg;
   logic tdo_mux;

   // *******************************************************************
   // Controller
   // *******************************************************************
   stap_fsm u_fsm (
      .tck        (tck),
      .arst_n     (arst_n),
      .tms        (tms),
      .state      (state),
      .capture_ir (capture_ir),
      .shift_ir   (shift_ir),
      .update_ir  (update_ir),
      .capture_dr (capture_dr),
      .shift_dr   (shift_dr),
      .update_dr  (update_dr),
      .ir_path    (ir_path),
      .tlr        (tlr)
   );

   // Instruction register, captures 0..01
   stap_shift_reg #(.payload_t(stap_reg_pkg::ir_t)) u_ir (
      .tck         (tck),
      .arst_n      (arst_n),
      .si          (tdi),
      .capture     (capture_ir),
      .shift       (shift_ir),
      .update      (update_ir),
      .tlr         (tlr),
      .capture_val (stap_reg_pkg::ir_t'(stap_reg_pkg::IR_CAPTURE)),
      .reset_val   (stap_reg_pkg::IR_IDCODE),
      .so          (ir_so),
      .data        (ir_data)
   );

   // *******************************************************************
   // Instruction decode, unknown codes fall into bypass
   // *******************************************************************
   assign sel_idcode = (ir_data == stap_reg_pkg::IR_IDCODE);
   assign sel_tapc   = (ir_data == stap_reg_pkg::IR_TAPC_SELECT);
   assign sel_bypass = !(sel_idcode || sel_tapc);

   // IDCODE is read-only, no update stage in use
   stap_shift_reg #(.payload_t(stap_reg_pkg::idcode_t)) u_idcode (
      .tck         (tck),
      .arst_n      (arst_n),
      .si          (tdi),
      .capture     (capture_dr & sel_idcode),
      .shift       (shift_dr & sel_idcode),
      .update      (1'b0),
      .tlr         (tlr),
      .capture_val (`STAP_IDCODE),
      .reset_val   (`STAP_IDCODE),
      .so          (id_so),
      .data        ()
   );

   // Select register, captures its current setting
   stap_shift_reg #(.payload_t(stap_reg_pkg::tapc_sel_t)) u_tapc_sel (
      .tck         (tck),
      .arst_n      (arst_n),
      .si          (tdi),
      .capture     (capture_dr & sel_tapc),
      .shift       (shift_dr & sel_tapc),
      .update      (update_dr & sel_tapc),
      .tlr         (tlr),
      .capture_val (sel_data),
      .reset_val   ('{default: stap_reg_pkg::MODE_ISOLATED}),
      .so          (sel_so),
      .data        (sel_data)
   );

   // Bypass bit
   always_ff @(posedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         bypass_q <= 1'b0;
      end
      else if (capture_dr && sel_bypass)
      begin
         bypass_q <= 1'b0;
      end
      else if (shift_dr && sel_bypass)
      begin
         bypass_q <= tdi;
      end
   end

   // *******************************************************************
   // TDO select and falling-edge stage
   // *******************************************************************
   assign tdo_mux = ir_path    ? ir_so :
                    sel_idcode ? id_so :
                    sel_tapc   ? sel_so : bypass_q;

   always_ff @(negedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ir_path_neg <= 1'b0;
         tdo         <= 1'b0;
         tdo_en      <= 1'b0;
      end
      else
      begin
         ir_path_neg <= ir_path;
         tdo         <= tdo_mux;
         // Drive only in the half cycle after a shift state
         tdo_en      <= (state == stap_fsm_pkg::SHIFT_IR) ||
                        (state == stap_fsm_pkg::SHIFT_DR);
      end
   end

   // Sub-TAP enables
   stap_tapnw u_tapnw (
      .select_ir   (ir_path_neg),
      .tapc_select (sel_data),
      .enabletap   (enabletap),
      .enabletdo   (enabletdo)
   );

endmodule

`default_nettype wire

/* tests/tb_stap.sv */
// *******************************************************************
// sTAP testbench: random JTAG scans against a TAP model, LFSR driven
// Run from the project root with sources.f
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stap_defines.svh"

module tb_stap;

   localparam int N_ROUNDS    = 16;
   // Longest round, IR scan plus two DR scans plus a TMS reset
   localparam int ROUND_BITS  = 128;
   localparam int PLAN_BITS   = (N_ROUNDS + 3) * ROUND_BITS;
   localparam int WATCHDOG_NS = PLAN_BITS * 4 * 2 + 200;
   localparam int SEL_BITS    = 2 * `STAP_NUM_TAPS;

   logic tck;
   logic arst_n;
   logic tms;
   logic tdi;
   logic tdo;
   logic tdo_en;
   stap_reg_pkg::tap_vec_t enabletap;
   stap_reg_pkg::tap_vec_t enabletdo;

   // Model of the sTAP
   stap_fsm_pkg::tap_state_t m_state;
   stap_reg_pkg::ir_t        m_ir;
   stap_reg_pkg::ir_t        m_ir_pend;
   stap_reg_pkg::tapc_sel_t  m_sel;
   stap_reg_pkg::tapc_sel_t  m_sel_pend;

   logic [31:0] lfsr;
   string       test_name;
   int          n_checks;
   int          err_value;
   int          err_proto;

   stap_top UUT (
      .tck       (tck),
      .arst_n    (arst_n),
      .tms       (tms),
      .tdi       (tdi),
      .tdo       (tdo),
      .tdo_en    (tdo_en),
      .enabletap (enabletap),
      .enabletdo (enabletdo)
   );

   always #2 tck = ~tck;

   // *******************************************************************
   // Random bits and model rules
   // *******************************************************************
   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   // 1149.1 transitions, grouped by TMS value
   function automatic stap_fsm_pkg::tap_state_t tap_next(input stap_fsm_pkg::tap_state_t s,
                                                         input logic t);
      stap_fsm_pkg::tap_state_t n;
      n = stap_fsm_pkg::TLR;
      if (t)
      begin
         case (s)
            stap_fsm_pkg::RTI, stap_fsm_pkg::UPDATE_DR, stap_fsm_pkg::UPDATE_IR:
               n = stap_fsm_pkg::SELECT_DR;
            stap_fsm_pkg::SELECT_DR: n = stap_fsm_pkg::SELECT_IR;
            stap_fsm_pkg::CAPTURE_DR, stap_fsm_pkg::SHIFT_DR: n = stap_fsm_pkg::EXIT1_DR;
            stap_fsm_pkg::EXIT1_DR, stap_fsm_pkg::EXIT2_DR: n = stap_fsm_pkg::UPDATE_DR;
            stap_fsm_pkg::PAUSE_DR: n = stap_fsm_pkg::EXIT2_DR;
            stap_fsm_pkg::CAPTURE_IR, stap_fsm_pkg::SHIFT_IR: n = stap_fsm_pkg::EXIT1_IR;
            stap_fsm_pkg::EXIT1_IR, stap_fsm_pkg::EXIT2_IR: n = stap_fsm_pkg::UPDATE_IR;
            stap_fsm_pkg::PAUSE_IR: n = stap_fsm_pkg::EXIT2_IR;
            default: n = stap_fsm_pkg::TLR;
         endcase
      end
      else
      begin
         case (s)
            stap_fsm_pkg::SELECT_DR: n = stap_fsm_pkg::CAPTURE_DR;
            stap_fsm_pkg::CAPTURE_DR, stap_fsm_pkg::SHIFT_DR, stap_fsm_pkg::EXIT2_DR:
               n = stap_fsm_pkg::SHIFT_DR;
            stap_fsm_pkg::EXIT1_DR, stap_fsm_pkg::PAUSE_DR: n = stap_fsm_pkg::PAUSE_DR;
            stap_fsm_pkg::SELECT_IR: n = stap_fsm_pkg::CAPTURE_IR;
            stap_fsm_pkg::CAPTURE_IR, stap_fsm_pkg::SHIFT_IR, stap_fsm_pkg::EXIT2_IR:
               n = stap_fsm_pkg::SHIFT_IR;
            stap_fsm_pkg::EXIT1_IR, stap_fsm_pkg::PAUSE_IR: n = stap_fsm_pkg::PAUSE_IR;
            default: n = stap_fsm_pkg::RTI;
         endcase
      end
      return n;
   endfunction

   // Select-IR through Update-IR
   function automatic logic in_ir_column(input stap_fsm_pkg::tap_state_t s);
      case (s)
         stap_fsm_pkg::SELECT_IR, stap_fsm_pkg::CAPTURE_IR, stap_fsm_pkg::SHIFT_IR,
         stap_fsm_pkg::EXIT1_IR, stap_fsm_pkg::PAUSE_IR, stap_fsm_pkg::EXIT2_IR,
         stap_fsm_pkg::UPDATE_IR: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic stap_reg_pkg::tap_vec_t exp_enabletap(input stap_reg_pkg::tapc_sel_t sel);
      stap_reg_pkg::tap_vec_t v;
      for (int j = 0; j < `STAP_NUM_TAPS; j++)
      begin
         v[j] = (sel[j] != stap_reg_pkg::MODE_ISOLATED);
      end
      return v;
   endfunction

   function automatic stap_reg_pkg::tap_vec_t exp_enabletdo(input stap_reg_pkg::tapc_sel_t sel,
                                                            input logic in_ir);
      stap_reg_pkg::tap_vec_t v;
      for (int j = 0; j < `STAP_NUM_TAPS; j++)
      begin
         case (sel[j])
            stap_reg_pkg::MODE_NORMAL   : v[j] = 1'b1;
            stap_reg_pkg::MODE_WIR_ONLY : v[j] = in_ir;
            default                     : v[j] = 1'b0;
         endcase
      end
      return v;
   endfunction

   // *******************************************************************
   // Compare tasks
   // *******************************************************************
   task automatic check_bit(input string what, input logic exp, input logic act);
      n_checks++;
      if (act !== exp)
      begin
         err_value++;
         $display("FAIL %s (%s): expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_ir(input string what, input stap_reg_pkg::ir_t exp,
                           input stap_reg_pkg::ir_t act);
      n_checks++;
      if (act !== exp)
      begin
         err_value++;
         $display("FAIL %s (%s): expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_vec(input string what, input stap_reg_pkg::tap_vec_t exp,
                            input stap_reg_pkg::tap_vec_t act);
      n_checks++;
      if (act !== exp)
      begin
         err_value++;
         $display("FAIL %s (%s): expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_idcode(input string what, input stap_reg_pkg::idcode_t exp,
                               input stap_reg_pkg::idcode_t act);
      n_checks++;
      if (act !== exp)
      begin
         err_value++;
         $display("FAIL %s (%s): expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_sel(input string what, input stap_reg_pkg::tapc_sel_t exp,
                            input stap_reg_pkg::tapc_sel_t act);
      n_checks++;
      if (act !== exp)
      begin
         err_value++;
         $display("FAIL %s (%s): expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   // *******************************************************************
   // JTAG bit level
   // *******************************************************************
   // Called at a rising edge, outputs sampled at the next one
   task automatic clock_bit(input logic tms_v, input logic tdi_v, output logic tdo_s);
      logic in_shift;
      tms <= tms_v;
      tdi <= tdi_v;
      @(posedge tck);
      tdo_s    = tdo;
      in_shift = (m_state == stap_fsm_pkg::SHIFT_IR) || (m_state == stap_fsm_pkg::SHIFT_DR);
      check_vec("enabletap", exp_enabletap(m_sel), enabletap);
      check_vec("enabletdo", exp_enabletdo(m_sel, in_ir_column(m_state)), enabletdo);
      if (in_shift && (tdo_en !== 1'b1))
      begin
         err_proto++;
         $display("tdo_en was not high while shifting in test %s", test_name);
      end
      else if (!in_shift)
      begin
         check_bit("tdo_en idle", 1'b0, tdo_en);
      end
      // Register effects of this edge
      if (m_state == stap_fsm_pkg::TLR)
      begin
         m_ir  = stap_reg_pkg::IR_IDCODE;
         m_sel = stap_reg_pkg::tapc_sel_t'(0);
      end
      else if (m_state == stap_fsm_pkg::UPDATE_IR)
      begin
         m_ir = m_ir_pend;
      end
      else if (m_state == stap_fsm_pkg::UPDATE_DR && m_ir == stap_reg_pkg::IR_TAPC_SELECT)
      begin
         m_sel = m_sel_pend;
      end
      m_state = tap_next(m_state, tms_v);
   endtask

   // Shift-xR through Update-xR to Run-Test/Idle, one optional Pause detour
   task automatic shift_bits(input logic [31:0] din, input int len, output logic [31:0] dout);
      int   detour_at;
      int   pauses;
      logic b;
      dout      = '0;
      detour_at = int'(take_bits(5));
      pauses    = int'(take_bits(2));
      for (int i = 0; i < len; i++)
      begin
         clock_bit((i == len - 1) || (i == detour_at), din[i], b);
         dout[i] = b;
         if ((i == detour_at) && (i != len - 1))
         begin
            clock_bit(1'b0, 1'b0, b);
            repeat (pauses) clock_bit(1'b0, 1'b0, b);
            clock_bit(1'b1, 1'b0, b);
            clock_bit(1'b0, 1'b0, b);
         end
      end
      clock_bit(1'b1, 1'b0, b);
      clock_bit(1'b0, 1'b0, b);
   endtask

   task automatic scan_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
      logic b;
      clock_bit(1'b1, 1'b0, b);
      clock_bit(1'b0, 1'b0, b);
      clock_bit(1'b0, 1'b0, b);
      shift_bits(din, len, dout);
   endtask

   // IR scan of twice the width, the filler comes back in the upper half
   task automatic scan_ir(input stap_reg_pkg::ir_t instr);
      stap_reg_pkg::ir_t filler;
      logic [31:0]       dout;
      logic              b;
      filler    = stap_reg_pkg::ir_t'(take_bits(`STAP_IR_WIDTH));
      m_ir_pend = instr;
      clock_bit(1'b1, 1'b0, b);
      clock_bit(1'b1, 1'b0, b);
      clock_bit(1'b0, 1'b0, b);
      clock_bit(1'b0, 1'b0, b);
      shift_bits({instr, filler}, 2 * `STAP_IR_WIDTH, dout);
      check_ir("ir capture", stap_reg_pkg::ir_t'(stap_reg_pkg::IR_CAPTURE),
               dout[`STAP_IR_WIDTH-1:0]);
      check_ir("ir readback", filler, dout[2*`STAP_IR_WIDTH-1:`STAP_IR_WIDTH]);
   endtask

   // *******************************************************************
   // Data register scans
   // *******************************************************************
   task automatic dr_idcode();
      logic [31:0] dout;
      scan_dr(take_bits(32), 32, dout);
      check_idcode("idcode", `STAP_IDCODE, dout);
   endtask

   // Bypass returns its captured 0, then tdi one bit late
   task automatic dr_bypass();
      logic [31:0] din;
      logic [31:0] dout;
      din = take_bits(8);
      scan_dr(din, 8, dout);
      check_bit("bypass capture", 1'b0, dout[0]);
      for (int i = 1; i < 8; i++)
      begin
         check_bit("bypass delay", din[i-1], dout[i]);
      end
   endtask

   task automatic dr_select(input stap_reg_pkg::tapc_sel_t vec);
      stap_reg_pkg::tapc_sel_t prev;
      logic [31:0]             din;
      logic [31:0]             dout;
      prev               = m_sel;
      m_sel_pend         = vec;
      din                = '0;
      din[SEL_BITS-1:0]  = vec;
      scan_dr(din, SEL_BITS, dout);
      check_sel("select readback", prev, stap_reg_pkg::tapc_sel_t'(dout[SEL_BITS-1:0]));
   endtask

   // Short random walk from Run-Test/Idle, then five TMS ones
   task automatic tms_reset();
      logic [31:0] walk;
      logic        b;
      m_sel_pend = m_sel;
      m_ir_pend  = m_ir;
      walk       = take_bits(2);
      if (walk == 3)
      begin
         walk = 2;
      end
      repeat (walk) clock_bit(take_bits(1) != 0, 1'b0, b);
      repeat (5) clock_bit(1'b1, 1'b0, b);
      clock_bit(1'b0, 1'b0, b);
   endtask

   // *******************************************************************
   // Watchdog
   // *******************************************************************
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout after %0d ns, scans did not finish", WATCHDOG_NS);
      $display("Errors found");
      $finish;
   end

   // *******************************************************************
   // Test sequence
   // *******************************************************************
   initial
   begin
      stap_reg_pkg::ir_t instr;
      logic              b;
      tck        = 1'b0;
      arst_n     = 1'b0;
      tms        = 1'b1;
      tdi        = 1'b0;
      lfsr       = 32'he6bf_d806;
      n_checks   = 0;
      err_value  = 0;
      err_proto  = 0;
      m_state    = stap_fsm_pkg::TLR;
      m_ir       = stap_reg_pkg::IR_IDCODE;
      m_ir_pend  = stap_reg_pkg::IR_IDCODE;
      m_sel      = stap_reg_pkg::tapc_sel_t'(0);
      m_sel_pend = stap_reg_pkg::tapc_sel_t'(0);
      repeat (2) @(posedge tck);
      arst_n <= 1'b1;

      // Enables off and IDCODE selected out of reset
      test_name = "reset";
      clock_bit(1'b0, 1'b0, b);
      dr_idcode();

      // Taps 0 and 3 WIR-only, tap 1 normal, tap 2 TAP-only
      test_name = "select directed";
      scan_ir(stap_reg_pkg::IR_TAPC_SELECT);
      dr_select(stap_reg_pkg::tapc_sel_t'(8'b10_11_01_10));
      test_name = "wir only";
      scan_ir(stap_reg_pkg::IR_BYPASS);
      dr_bypass();

      for (int r = 0; r < N_ROUNDS; r++)
      begin
         case (take_bits(2))
            0: instr = stap_reg_pkg::IR_BYPASS;
            1: instr = stap_reg_pkg::ir_t'(take_bits(`STAP_IR_WIDTH));
            2: instr = stap_reg_pkg::IR_TAPC_SELECT;
            default: instr = stap_reg_pkg::IR_IDCODE;
         endcase
         test_name = $sformatf("round %0d ir %h", r, instr);
         scan_ir(instr);
         if (instr == stap_reg_pkg::IR_TAPC_SELECT)
         begin
            dr_select(stap_reg_pkg::tapc_sel_t'(take_bits(SEL_BITS)));
            dr_select(stap_reg_pkg::tapc_sel_t'(take_bits(SEL_BITS)));
         end
         else if (instr == stap_reg_pkg::IR_IDCODE)
         begin
            dr_idcode();
         end
         else
         begin
            dr_bypass();
         end
         if (r % 4 == 3)
         begin
            test_name = $sformatf("round %0d tlr", r);
            tms_reset();
            dr_idcode();
         end
      end

      $display("Checks %0d, value errors %0d, protocol errors %0d",
               n_checks, err_value, err_proto);
      if (err_value + err_proto == 0)
      begin
         $display("No errors");
      end
      else
      begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/stap_fsm_pkg.sv
hw/stap_reg_pkg.sv
hw/stap_fsm.sv
hw/stap_shift_reg.sv
hw/stap_tapnw.sv
hw/stap_top.sv
tests/tb_stap.sv

/* Bender.yml */
package:
  name: stap

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/stap_fsm_pkg.sv
      - hw/stap_reg_pkg.sv
      - hw/stap_fsm.sv
      - hw/stap_shift_reg.sv
      - hw/stap_tapnw.sv
      - hw/stap_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_stap.sv
